// File: source/mxint_pkg.sv
`default_nettype none

package mxint_pkg;

  // block format
  localparam int MANT_W     = 4;  // input mantissa, signed
  localparam int EXP_W      = 8;  // shared block exponent, two's complement
  localparam int BLOCK_SIZE = 4;  // lanes per block
  localparam int IN_DEPTH   = 4;  // product blocks summed into one result

  // product of two input mantissas is exact at twice the width
  localparam int PROD_W = 2 * MANT_W;

  // growth for IN_DEPTH additions
  localparam int ACC_W = PROD_W + $clog2(IN_DEPTH);

  // signed exponent range
  // EXP_MIN also marks an empty accumulator
  localparam logic [EXP_W-1:0] EXP_MIN = {1'b1, {(EXP_W-1){1'b0}}};
  localparam logic [EXP_W-1:0] EXP_MAX = {1'b0, {(EXP_W-1){1'b1}}};

  // alignment shift limits, operand width minus one
  // a larger shift would give the same 0 or -1
  localparam logic [EXP_W-1:0] SHIFT_MAX_PROD = EXP_W'(PROD_W - 1);
  localparam logic [EXP_W-1:0] SHIFT_MAX_ACC  = EXP_W'(ACC_W - 1);

  // group counter
  // one bit wider so that IN_DEPTH itself fits
  localparam int CNT_W = $clog2(IN_DEPTH) + 1;

  localparam logic [CNT_W-1:0] CNT_ONE  = CNT_W'(1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(IN_DEPTH);  // result ready

endpackage

`default_nettype wire

// File: source/mxint_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// one MXINT block per transfer: BLOCK_SIZE mantissas sharing one exponent
interface mxint_stream_if #(
  parameter int MW = mxint_pkg::PROD_W  // mantissa width of this stream
) ();

  logic [MW-1:0]               mant [mxint_pkg::BLOCK_SIZE];
  logic [mxint_pkg::EXP_W-1:0] exp;    // signed shared exponent
  logic                        valid;
  logic                        ready;

  modport src (
    output mant,
    output exp,
    output valid,
    input  ready
  );

  modport snk (
    input  mant,
    input  exp,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

// File: source/mxint_block_mul.sv
`timescale 1ns/1ps
`default_nettype none

module mxint_block_mul (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [mxint_pkg::MANT_W-1:0] a_mant [mxint_pkg::BLOCK_SIZE],
  input  logic [mxint_pkg::MANT_W-1:0] w_mant [mxint_pkg::BLOCK_SIZE],
  input  logic [mxint_pkg::EXP_W-1:0]  a_exp,
  input  logic [mxint_pkg::EXP_W-1:0]  w_exp,
  input  logic                         in_valid,
  output logic                         in_ready,
  mxint_stream_if.src                  prod
);

  logic signed [mxint_pkg::PROD_W-1:0] a_ext [mxint_pkg::BLOCK_SIZE];
  logic signed [mxint_pkg::PROD_W-1:0] w_ext [mxint_pkg::BLOCK_SIZE];
  logic signed [mxint_pkg::PROD_W-1:0] lane_prod [mxint_pkg::BLOCK_SIZE];

  logic [mxint_pkg::EXP_W:0]   exp_sum;  // one guard bit
  logic [mxint_pkg::EXP_W-1:0] exp_sat;
  logic                        load;

  // single stage, accepts while empty or while its block leaves
  assign in_ready = !prod.valid || prod.ready;
  assign load     = in_valid && in_ready;

  // lane-wise signed multiply
  always_comb begin
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      a_ext[i] = {{(mxint_pkg::PROD_W - mxint_pkg::MANT_W){a_mant[i][mxint_pkg::MANT_W-1]}},
                  a_mant[i]};
      w_ext[i] = {{(mxint_pkg::PROD_W - mxint_pkg::MANT_W){w_mant[i][mxint_pkg::MANT_W-1]}},
                  w_mant[i]};
      lane_prod[i] = a_ext[i] * w_ext[i];  // exact, fits in PROD_W
    end
  end

  // exponents add, clamp on signed overflow
  always_comb begin
    exp_sum = {a_exp[mxint_pkg::EXP_W-1], a_exp} + {w_exp[mxint_pkg::EXP_W-1], w_exp};

    // guard bit and sign bit disagree only when the sum left the range
    if (exp_sum[mxint_pkg::EXP_W] != exp_sum[mxint_pkg::EXP_W-1]) begin
      exp_sat = exp_sum[mxint_pkg::EXP_W] ? mxint_pkg::EXP_MIN : mxint_pkg::EXP_MAX;
    end else begin
      exp_sat = exp_sum[mxint_pkg::EXP_W-1:0];
    end
  end

  // valid flag
  always_ff @(posedge clk) begin
    if (rst) begin
      prod.valid <= 1'b0;
    end else if (in_ready) begin
      prod.valid <= in_valid;  // drops when drained with nothing behind it
    end
  end

  // product block register
  always_ff @(posedge clk) begin
    if (load) begin
      prod.exp <= exp_sat;
      for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
        prod.mant[i] <= lane_prod[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mxint_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

// sums IN_DEPTH product blocks lane by lane
// each step aligns both operands to the larger exponent first
module mxint_accumulator (
  input logic         clk,
  input logic         rst,
  mxint_stream_if.snk din,   // PROD_W mantissas
  mxint_stream_if.src dout   // ACC_W mantissas
);

  logic [mxint_pkg::CNT_W-1:0] count;  // inputs in the current group
  logic                        empty;
  logic                        take;
  logic                        accept;

  logic [mxint_pkg::EXP_W-1:0] exp_big;
  logic [mxint_pkg::EXP_W-1:0] sh_in_raw;
  logic [mxint_pkg::EXP_W-1:0] sh_acc_raw;
  logic [mxint_pkg::EXP_W-1:0] sh_in;
  logic [mxint_pkg::EXP_W-1:0] sh_acc;

  logic signed [mxint_pkg::ACC_W-1:0] in_ext  [mxint_pkg::BLOCK_SIZE];
  logic signed [mxint_pkg::ACC_W-1:0] in_sh   [mxint_pkg::BLOCK_SIZE];
  logic signed [mxint_pkg::ACC_W-1:0] acc_sh  [mxint_pkg::BLOCK_SIZE];
  logic signed [mxint_pkg::ACC_W-1:0] acc_sum [mxint_pkg::BLOCK_SIZE];

  assign dout.valid = (count == mxint_pkg::CNT_FULL);
  assign din.ready  = !dout.valid || dout.ready;  // hold off while a result waits
  assign empty      = (count == '0);
  assign take       = dout.valid && dout.ready;
  assign accept     = din.valid && din.ready;

  // larger signed exponent of register and input
  assign exp_big = ($signed(din.exp) > $signed(dout.exp)) ? din.exp : dout.exp;

  // shift distances, never negative since exp_big is the max
  always_comb begin
    sh_in_raw  = exp_big - din.exp;
    sh_acc_raw = exp_big - dout.exp;

    sh_in  = (sh_in_raw > mxint_pkg::SHIFT_MAX_PROD) ? mxint_pkg::SHIFT_MAX_PROD : sh_in_raw;
    sh_acc = (sh_acc_raw > mxint_pkg::SHIFT_MAX_ACC) ? mxint_pkg::SHIFT_MAX_ACC : sh_acc_raw;
  end

  // align and add, truncating toward minus infinity
  always_comb begin
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      in_ext[i] = {{(mxint_pkg::ACC_W - mxint_pkg::PROD_W){din.mant[i][mxint_pkg::PROD_W-1]}},
                   din.mant[i]};
      in_sh[i]   = in_ext[i] >>> sh_in;
      acc_sh[i]  = $signed(dout.mant[i]) >>> sh_acc;
      acc_sum[i] = acc_sh[i] + in_sh[i];  // ACC_W covers IN_DEPTH sums
    end
  end

  // group counter
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (dout.valid) begin
      if (dout.ready) begin
        count <= din.valid ? mxint_pkg::CNT_ONE : '0;  // next group may start at once
      end
    end else if (accept) begin
      count <= count + mxint_pkg::CNT_ONE;
    end
  end

  // shared exponent
  always_ff @(posedge clk) begin
    if (rst) begin
      dout.exp <= mxint_pkg::EXP_MIN;
    end else if (take) begin
      dout.exp <= din.valid ? din.exp : mxint_pkg::EXP_MIN;
    end else if (accept) begin
      dout.exp <= empty ? din.exp : exp_big;
    end
  end

  // mantissa lanes
  // an empty register loads the input unshifted
  always_ff @(posedge clk) begin
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      if (take) begin
        dout.mant[i] <= din.valid ? in_ext[i] : '0;
      end else if (accept) begin
        dout.mant[i] <= empty ? in_ext[i] : acc_sum[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mxint_dot_top.sv
`timescale 1ns/1ps
`default_nettype none

module mxint_dot_top (
  input  logic                                                    clk,
  input  logic                                                    rst,

  // activations, lane 0 in the low bits
  input  logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::MANT_W-1:0] a_mant,
  input  logic [mxint_pkg::EXP_W-1:0]                             a_exp,
  input  logic                                                    a_valid,
  output logic                                                    a_ready,

  // weights
  input  logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::MANT_W-1:0] w_mant,
  input  logic [mxint_pkg::EXP_W-1:0]                             w_exp,
  input  logic                                                    w_valid,
  output logic                                                    w_ready,

  // result blocks
  output logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::ACC_W-1:0]  r_mant,
  output logic [mxint_pkg::EXP_W-1:0]                             r_exp,
  output logic                                                    r_valid,
  input  logic                                                    r_ready
);

  mxint_stream_if #(.MW(mxint_pkg::PROD_W)) prod ();
  mxint_stream_if #(.MW(mxint_pkg::ACC_W))  res ();

  logic [mxint_pkg::MANT_W-1:0] a_lane [mxint_pkg::BLOCK_SIZE];
  logic [mxint_pkg::MANT_W-1:0] w_lane [mxint_pkg::BLOCK_SIZE];
  logic                         mul_ready;
  logic                         pair_valid;

  // a pair moves only when both halves are present
  assign pair_valid = a_valid && w_valid;
  assign a_ready    = mul_ready && w_valid;
  assign w_ready    = mul_ready && a_valid;

  always_comb begin
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      a_lane[i] = a_mant[i];
      w_lane[i] = w_mant[i];
    end
  end

  mxint_block_mul i_block_mul (
    .clk      (clk),
    .rst      (rst),
    .a_mant   (a_lane),
    .w_mant   (w_lane),
    .a_exp    (a_exp),
    .w_exp    (w_exp),
    .in_valid (pair_valid),
    .in_ready (mul_ready),
    .prod     (prod)
  );

  mxint_accumulator i_accumulator (
    .clk  (clk),
    .rst  (rst),
    .din  (prod),
    .dout (res)
  );

  // result stream back onto flat ports
  always_comb begin
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      r_mant[i] = res.mant[i];
    end
  end

  assign r_exp     = res.exp;
  assign r_valid   = res.valid;
  assign res.ready = r_ready;

endmodule

`default_nettype wire

// File: test/mxint_dot_chk.sv
`timescale 1ns/1ps
`default_nettype none

// handshake and reset properties on the top-level ports
module mxint_dot_chk (
  input logic                                                   clk,
  input logic                                                   rst,
  input logic                                                   a_valid,
  input logic                                                   a_ready,
  input logic                                                   w_valid,
  input logic                                                   w_ready,
  input logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::ACC_W-1:0] r_mant,
  input logic [mxint_pkg::EXP_W-1:0]                            r_exp,
  input logic                                                   r_valid,
  input logic                                                   r_ready
);

  // counter clears on reset, so no result is pending one cycle later
  no_result_after_reset: assert property (@(posedge clk) rst |=> !r_valid)
    else $error("r_valid high in the cycle after reset");

  // a result that is not taken keeps its value
  result_held: assert property (@(posedge clk) disable iff (rst)
      r_valid && !r_ready |=> r_valid && $stable(r_mant) && $stable(r_exp))
    else $error("result dropped or changed while r_ready was low");

  a_ready_needs_w: assert property (@(posedge clk) a_ready |-> w_valid)
    else $error("a_ready high while w_valid is low");

  w_ready_needs_a: assert property (@(posedge clk) w_ready |-> a_valid)
    else $error("w_ready high while a_valid is low");

endmodule

`default_nettype wire

// File: test/mxint_dot_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mxint_dot_tb;

  localparam int PAIR_WORDS    = 10;  // a_exp, a lanes, w_exp, w lanes
  localparam int GROUP_WORDS   = mxint_pkg::IN_DEPTH * PAIR_WORDS + 5;
  localparam int N_GROUPS      = 4;
  localparam int TRACE_WORDS   = N_GROUPS * GROUP_WORDS;
  localparam int TOTAL_RESULTS = 2 * N_GROUPS;  // trace runs twice
  localparam int HS_TIMEOUT    = 200;         // cycles per input pair
  localparam int RES_TIMEOUT   = 1000;

  logic                                                    clk;
  logic                                                    rst;
  logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::MANT_W-1:0] a_mant;
  logic [mxint_pkg::EXP_W-1:0]                             a_exp;
  logic                                                    a_valid;
  logic                                                    a_ready;
  logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::MANT_W-1:0] w_mant;
  logic [mxint_pkg::EXP_W-1:0]                             w_exp;
  logic                                                    w_valid;
  logic                                                    w_ready;
  logic [mxint_pkg::BLOCK_SIZE-1:0][mxint_pkg::ACC_W-1:0]  r_mant;
  logic [mxint_pkg::EXP_W-1:0]                             r_exp;
  logic                                                    r_valid;
  logic                                                    r_ready;

  logic [15:0] trace_mem [TRACE_WORDS];
  logic        stall_en;   // random input gaps and r_ready stalls
  logic        timed_out;

  int pairs_in    = 0;  // pairs accepted so far
  int res_idx     = 0;  // results taken so far
  int mant_errors = 0;
  int exp_errors  = 0;
  int flow_errors = 0;
  int timeouts    = 0;

  mxint_dot_top i_mxint_dot_top (
    .clk     (clk),
    .rst     (rst),
    .a_mant  (a_mant),
    .a_exp   (a_exp),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .w_mant  (w_mant),
    .w_exp   (w_exp),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .r_mant  (r_mant),
    .r_exp   (r_exp),
    .r_valid (r_valid),
    .r_ready (r_ready)
  );

  bind mxint_dot_top mxint_dot_chk i_dot_chk (
    .clk     (clk),
    .rst     (rst),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .r_mant  (r_mant),
    .r_exp   (r_exp),
    .r_valid (r_valid),
    .r_ready (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_mant(input string name, input logic [mxint_pkg::ACC_W-1:0] expected,
                            input logic [mxint_pkg::ACC_W-1:0] actual);
    if (actual !== expected) begin
      mant_errors++;
      $display("Error at %0t: %s expected %0d actual %0d", $time, name,
               $signed(expected), $signed(actual));
    end
  endtask

  task automatic check_exp(input string name, input logic [mxint_pkg::EXP_W-1:0] expected,
                           input logic [mxint_pkg::EXP_W-1:0] actual);
    if (actual !== expected) begin
      exp_errors++;
      $display("Error at %0t: %s expected %0d actual %0d", $time, name,
               $signed(expected), $signed(actual));
    end
  endtask

  task automatic compare_result(input int group);
    int base;
    base = group * GROUP_WORDS + mxint_pkg::IN_DEPTH * PAIR_WORDS;  // result line
    check_exp("r_exp", trace_mem[base][mxint_pkg::EXP_W-1:0], r_exp);
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      check_mant($sformatf("r_mant[%0d]", i), trace_mem[base + 1 + i][mxint_pkg::ACC_W-1:0],
                 r_mant[i]);
    end
  endtask

  // presents one pair and holds it until both streams transfer
  task automatic send_pair(input int base);
    int   cycles;
    logic a_on;
    logic w_on;
    logic done;
    @(negedge clk);
    a_exp = trace_mem[base][mxint_pkg::EXP_W-1:0];
    w_exp = trace_mem[base + 5][mxint_pkg::EXP_W-1:0];
    for (int i = 0; i < mxint_pkg::BLOCK_SIZE; i++) begin
      a_mant[i] = trace_mem[base + 1 + i][mxint_pkg::MANT_W-1:0];
      w_mant[i] = trace_mem[base + 6 + i][mxint_pkg::MANT_W-1:0];
    end
    a_on   = !stall_en || ($urandom_range(1) == 0);
    w_on   = !stall_en || ($urandom_range(1) == 0);
    cycles = 0;
    done   = 1'b0;
    while (!done && !timed_out) begin
      a_valid = a_on;
      w_valid = w_on;
      @(posedge clk);
      if (a_valid && a_ready && w_valid && w_ready) begin
        done = 1'b1;
      end else if (cycles == HS_TIMEOUT) begin
        timeouts++;
        timed_out = 1'b1;
        $display("timeout: the input pair at trace word %0d was never accepted", base);
      end else begin
        cycles++;
        @(negedge clk);
        a_on = a_on || ($urandom_range(1) == 0);  // once valid, stays valid
        w_on = w_on || ($urandom_range(1) == 0);
      end
    end
  endtask

  task automatic drive_trace();
    for (int g = 0; g < N_GROUPS; g++) begin
      for (int p = 0; p < mxint_pkg::IN_DEPTH; p++) begin
        if (!timed_out) begin
          send_pair(g * GROUP_WORDS + p * PAIR_WORDS);
        end
      end
    end
    @(negedge clk);
    a_valid = 1'b0;
    w_valid = 1'b0;
  endtask

  task automatic wait_results(input int count);
    int cycles;
    cycles = 0;
    while (res_idx < count && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles > RES_TIMEOUT) begin
        timeouts++;
        timed_out = 1'b1;
        $display("timeout: only %0d of %0d result blocks arrived", res_idx, count);
      end
    end
  endtask

  // result monitor, compares in trace order
  always @(posedge clk) begin
    if (!rst) begin
      if (r_valid && pairs_in < mxint_pkg::IN_DEPTH * (res_idx + 1)) begin
        flow_errors++;
        $display("r_valid was high at %0t before its group had been accepted", $time);
      end
      if (r_valid && r_ready) begin
        if (res_idx >= TOTAL_RESULTS) begin
          flow_errors++;
          $display("an unexpected extra result block appeared at %0t", $time);
        end else begin
          compare_result(res_idx % N_GROUPS);
        end
        res_idx++;
      end
      if (a_valid && a_ready && w_valid && w_ready) begin
        pairs_in++;
      end
    end
  end

  initial begin
    r_ready = 1'b1;
    forever begin
      @(negedge clk);
      r_ready = stall_en ? ($urandom_range(2) != 0) : 1'b1;
    end
  end

  initial begin
    rst       = 1'b1;
    a_mant    = '0;
    a_exp     = '0;
    a_valid   = 1'b0;
    w_mant    = '0;
    w_exp     = '0;
    w_valid   = 1'b0;
    stall_en  = 1'b0;
    timed_out = 1'b0;
    void'($urandom(32'h82cfd130));
    $readmemh("test/mxint_dot_trace.txt", trace_mem);

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // back-to-back groups with r_ready high
    drive_trace();
    wait_results(N_GROUPS);

    // the same groups again under gaps and stalls
    stall_en = 1'b1;
    drive_trace();
    wait_results(TOTAL_RESULTS);

    $display("mantissa errors %0d, exponent errors %0d, flow errors %0d, timeouts %0d",
             mant_errors, exp_errors, flow_errors, timeouts);
    if (!timed_out && mant_errors == 0 && exp_errors == 0 && flow_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/mxint_dot_trace.txt
// pair line: a_exp a_mant[0] a_mant[1] a_mant[2] a_mant[3] w_exp w_mant[0..3]
// after every four pairs, result line: r_exp r_mant[0..3]; all two's complement hex
// equal exponents
02 1 2 3 4 01 1 1 1 1
02 f e d c 01 2 2 2 2
02 7 8 5 a 01 7 8 d 3
02 0 3 9 2 01 5 b 6 7
03 030 02f 3c4 3f8
// differing exponents, truncating alignment
00 3 d 5 f 00 3 3 3 7
01 2 2 c 1 01 3 f 1 1
00 7 b 6 9 01 1 1 1 1
02 1 f 2 4 01 5 5 d e
03 00a 3f7 3fb 3f5
// clamped shifts on large exponent gaps
f6 7 9 3 d 00 7 7 e e
0a 1 2 f 0 0a 1 1 1 1
00 7 9 8 1 00 7 7 1 1
05 2 e 3 4 0f 3 3 1 f
14 007 3fa 000 3fc
// exponent saturation at both ends
9c 1 f 2 e 9c 4 4 4 4
80 1 1 1 1 00 1 2 3 8
64 7 8 4 0 64 7 7 1 0
7f 2 1 f 3 00 1 1 4 5
7f 033 3c8 000 00e

// File: sim.f
source/mxint_pkg.sv
source/mxint_stream_if.sv
source/mxint_block_mul.sv
source/mxint_accumulator.sv
source/mxint_dot_top.sv
test/mxint_dot_chk.sv
test/mxint_dot_tb.sv

// File: Makefile
SIM  = obj_dir/Vmxint_dot_tb
SRCS = $(wildcard source/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) sim.f
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module mxint_dot_tb --Mdir obj_dir -o Vmxint_dot_tb -f sim.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
